// File: hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width.
`define XLEN        32

// Register index width, 32 registers.
`define REG_BITS    5

// Receive buffer entries, also the source's credits after reset.
`define IBUF_DEPTH  4

// Retire credits held by the core after reset.
`define RET_CREDITS 2

`endif

// File: hdl/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0]     word_t;
    typedef logic [`REG_BITS-1:0] reg_idx_t;
    typedef logic [31:0]          instr_word_t;

    // Major opcodes. Everything else is illegal.
    typedef enum logic [6:0]
    {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    typedef enum logic [2:0]
    {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101, // SRL or SRA, picked by funct7.
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

endpackage

// File: hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // LUI.
    } alu_op_t;

    typedef struct packed
    {
        logic                      valid;
        rv_isa_pkg::instr_word_t   instr;
    } instr_in_t;

    typedef struct packed
    {
        logic                      valid;
        logic                      illegal;
        rv_isa_pkg::reg_idx_t      rs1;
        rv_isa_pkg::reg_idx_t      rs2;
        rv_isa_pkg::reg_idx_t      rd;
        alu_op_t                   alu_op;
        logic                      use_imm;
        rv_isa_pkg::word_t         imm;
        logic                      reg_write;
    } decoded_t;

    typedef struct packed
    {
        logic                      valid;
        logic                      illegal;
        rv_isa_pkg::reg_idx_t      rd;
        logic                      reg_write;
        rv_isa_pkg::word_t         data;
    } exec_t;

    typedef struct packed
    {
        logic                      valid;
        logic                      illegal;
        rv_isa_pkg::reg_idx_t      rd;
        rv_isa_pkg::word_t         data;
    } retire_t;

endpackage

// File: hdl/rv_instr_buf.sv
`include "rv_defs.svh"

module rv_instr_buf
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_pipe_pkg::instr_in_t  i_instr,
    input  wire                     i_advance,
    output rv_pipe_pkg::instr_in_t  o_head,
    output logic                    o_instr_credit
);

    import rv_isa_pkg::*;

    localparam int PTR_BITS = $clog2(`IBUF_DEPTH);
    localparam int CNT_BITS = $clog2(`IBUF_DEPTH + 1);

    instr_word_t            mem [`IBUF_DEPTH];
    logic [PTR_BITS-1:0]    wr_ptr;
    logic [PTR_BITS-1:0]    rd_ptr;
    logic [CNT_BITS-1:0]    count;
    logic                   push;
    logic                   pop;

    // No full check, the source never exceeds its credits.
    assign push = i_instr.valid;
    assign pop  = i_advance && (count != '0);

    always_comb
    begin
        o_head.valid = (count != '0);
        o_head.instr = mem[rd_ptr];
    end

    always_ff @(posedge i_clk)
    begin
        if (push)
            mem[wr_ptr] <= i_instr.instr;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            count          <= '0;
            o_instr_credit <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_BITS'(`IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_BITS'(`IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count          <= count + CNT_BITS'(push) - CNT_BITS'(pop);
            o_instr_credit <= pop; // One credit back per entry taken.
        end
    end

endmodule

// File: hdl/rv_decode.sv
module rv_decode
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_pipe_pkg::instr_in_t  i_head,
    input  wire                     i_advance,
    output rv_pipe_pkg::decoded_t   o_dec,
    output rv_isa_pkg::reg_idx_t    o_rs1,
    output rv_isa_pkg::reg_idx_t    o_rs2
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_t        opcode;
    funct3_t        funct3;
    logic [6:0]     funct7;
    logic           f7_zero;
    logic           f7_alt;
    decoded_t       dec;

    assign opcode  = opcode_t'(i_head.instr[6:0]);
    assign funct3  = funct3_t'(i_head.instr[14:12]);
    assign funct7  = i_head.instr[31:25];
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb
    begin
        dec.valid   = i_head.valid;
        dec.illegal = 1'b0;
        dec.rs1     = i_head.instr[19:15];
        dec.rs2     = i_head.instr[24:20];
        dec.rd      = i_head.instr[11:7];
        dec.alu_op  = ALU_ADD;
        dec.use_imm = 1'b1;
        dec.imm     = word_t'($signed(i_head.instr[31:20])); // I-type.
        case (opcode)
            OPC_LUI:
            begin
                dec.alu_op = ALU_PASS_B;
                dec.imm    = word_t'($signed({i_head.instr[31:12], 12'b0}));
            end
            OPC_OP_IMM:
            begin
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = ALU_ADD;
                    F3_SLL:     dec.alu_op = ALU_SLL;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_SR:      dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                endcase
                // Shift immediates carry funct7 in the upper bits.
                if (funct3 == F3_SLL)
                    dec.illegal = !f7_zero;
                else if (funct3 == F3_SR)
                    dec.illegal = !(f7_zero || f7_alt);
            end
            OPC_OP:
            begin
                dec.use_imm = 1'b0;
                case (funct3)
                    F3_ADD_SUB: dec.alu_op = f7_alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     dec.alu_op = ALU_SLL;
                    F3_SLT:     dec.alu_op = ALU_SLT;
                    F3_SLTU:    dec.alu_op = ALU_SLTU;
                    F3_XOR:     dec.alu_op = ALU_XOR;
                    F3_SR:      dec.alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      dec.alu_op = ALU_OR;
                    F3_AND:     dec.alu_op = ALU_AND;
                endcase
                if (funct3 == F3_ADD_SUB || funct3 == F3_SR)
                    dec.illegal = !(f7_zero || f7_alt);
                else
                    dec.illegal = !f7_zero;
            end
            default: dec.illegal = 1'b1;
        endcase
        dec.reg_write = !dec.illegal;
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_dec <= '0;
        else if (i_advance)
            o_dec <= dec;
    end

    // Register file is read in the execute cycle.
    assign o_rs1 = o_dec.rs1;
    assign o_rs2 = o_dec.rs2;

endmodule

// File: hdl/rv_regs.sv
`include "rv_defs.svh"

module rv_regs
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_isa_pkg::reg_idx_t    i_rs1,
    input  rv_isa_pkg::reg_idx_t    i_rs2,
    input  wire                     i_we,
    input  rv_isa_pkg::reg_idx_t    i_rd,
    input  rv_isa_pkg::word_t       i_wdata,
    output rv_isa_pkg::word_t       o_rdata1,
    output rv_isa_pkg::word_t       o_rdata2
);

    import rv_isa_pkg::*;

    localparam int NUM_REGS = 1 << `REG_BITS;

    word_t  regs [1:NUM_REGS-1]; // x0 is not stored.

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_rd != '0)
            regs[i_rd] <= i_wdata;
    end

    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: hdl/rv_execute.sv
`include "rv_defs.svh"

module rv_execute
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_pipe_pkg::decoded_t   i_dec,
    input  rv_isa_pkg::word_t       i_rdata1,
    input  rv_isa_pkg::word_t       i_rdata2,
    input  wire                     i_advance,
    output rv_pipe_pkg::exec_t      o_exec
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic                   fwd_ok;
    logic                   fwd1;
    logic                   fwd2;
    word_t                  op_a;
    word_t                  op_rs2;
    word_t                  op_b;
    logic [SHAMT_BITS-1:0]  shamt;
    word_t                  alu_res;

    // The older instruction in o_exec is not yet in the register file.
    assign fwd_ok = o_exec.valid && o_exec.reg_write && (o_exec.rd != '0);
    assign fwd1   = fwd_ok && (o_exec.rd == i_dec.rs1);
    assign fwd2   = fwd_ok && (o_exec.rd == i_dec.rs2);

    assign op_a   = fwd1 ? o_exec.data : i_rdata1;
    assign op_rs2 = fwd2 ? o_exec.data : i_rdata2;
    assign op_b   = i_dec.use_imm ? i_dec.imm : op_rs2;
    assign shamt  = op_b[SHAMT_BITS-1:0];

    always_comb
    begin
        alu_res = '0;
        case (i_dec.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res[0] = ($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res[0] = (op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_exec <= '0;
        else if (i_advance)
        begin
            o_exec.valid     <= i_dec.valid;
            o_exec.illegal   <= i_dec.illegal;
            o_exec.rd        <= i_dec.rd;
            o_exec.reg_write <= i_dec.reg_write;
            o_exec.data      <= i_dec.illegal ? '0 : alu_res; // Illegal retires zero.
        end
    end

endmodule

// File: hdl/rv_result.sv
`include "rv_defs.svh"

module rv_result
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_pipe_pkg::exec_t      i_exec,
    input  wire                     i_ret_credit,
    output logic                    o_advance,
    output logic                    o_we,
    output rv_isa_pkg::reg_idx_t    o_rd,
    output rv_isa_pkg::word_t       o_wdata,
    output rv_pipe_pkg::retire_t    o_ret
);

    localparam int CRED_BITS = $clog2(`RET_CREDITS + 1);

    logic [CRED_BITS-1:0]   ret_credits;
    logic                   retire;

    // A credit returned this cycle can be spent at once.
    assign o_advance = (ret_credits != '0) || i_ret_credit;
    assign retire    = o_advance && i_exec.valid;

    assign o_we    = retire && i_exec.reg_write;
    assign o_rd    = i_exec.rd;
    assign o_wdata = i_exec.data;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ret_credits <= CRED_BITS'(`RET_CREDITS);
            o_ret       <= '0;
        end
        else
        begin
            ret_credits   <= ret_credits + CRED_BITS'(i_ret_credit) - CRED_BITS'(retire);
            o_ret.valid   <= retire;
            o_ret.illegal <= i_exec.illegal;
            o_ret.rd      <= i_exec.rd;
            o_ret.data    <= i_exec.data;
        end
    end

endmodule

// File: hdl/rv_core.sv
module rv_core
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  rv_pipe_pkg::instr_in_t  i_instr,
    output logic                    o_instr_credit,
    output rv_pipe_pkg::retire_t    o_ret,
    input  wire                     i_ret_credit
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic       advance;
    instr_in_t  head;
    decoded_t   dec;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      rdata1;
    word_t      rdata2;
    exec_t      exec;
    logic       we;
    reg_idx_t   wr_rd;
    word_t      wr_data;

    rv_instr_buf u_buf
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr        (i_instr),
        .i_advance      (advance),
        .o_head         (head),
        .o_instr_credit (o_instr_credit)
    );

    rv_decode u_decode
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_head         (head),
        .i_advance      (advance),
        .o_dec          (dec),
        .o_rs1          (rs1),
        .o_rs2          (rs2)
    );

    rv_regs u_regs
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_rs1          (rs1),
        .i_rs2          (rs2),
        .i_we           (we),
        .i_rd           (wr_rd),
        .i_wdata        (wr_data),
        .o_rdata1       (rdata1),
        .o_rdata2       (rdata2)
    );

    rv_execute u_execute
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_dec          (dec),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .i_advance      (advance),
        .o_exec         (exec)
    );

    rv_result u_result
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_exec         (exec),
        .i_ret_credit   (i_ret_credit),
        .o_advance      (advance),
        .o_we           (we),
        .o_rd           (wr_rd),
        .o_wdata        (wr_data),
        .o_ret          (o_ret)
    );

endmodule

// File: testbench/rv_core_chk.sv
`include "rv_defs.svh"

module rv_core_chk
#(
    parameter int CRED_BITS = $clog2(`RET_CREDITS + 1),
    parameter int CNT_BITS  = $clog2(`IBUF_DEPTH + 1)
)
(
    input  wire                     i_clk,
    input  wire                     i_arst_n,
    input  wire [CRED_BITS-1:0]     i_ret_credits,
    input  wire [CNT_BITS-1:0]      i_buf_count,
    input  wire                     i_ret_credit,
    input  wire                     i_ret_valid
);

    int fail_count = 0; // Read by the testbench at the end.

    // A wrap below zero shows up as a count above the reset value.
    a_ret_credits: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ret_credits <= CRED_BITS'(`RET_CREDITS))
    else
    begin
        fail_count++;
        $error("retire credit count left its range");
    end

    a_buf_count: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_buf_count <= CNT_BITS'(`IBUF_DEPTH))
    else
    begin
        fail_count++;
        $error("instruction buffer holds more entries than it has");
    end

    // Advance needs a held credit or one coming back.
    a_ret_advance: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ret_valid |-> $past((i_ret_credits != '0) || i_ret_credit))
    else
    begin
        fail_count++;
        $error("retire presented without a retire credit");
    end

endmodule

// File: testbench/rv_core_tb.sv
`include "rv_defs.svh"

module rv_core_tb;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int NUM_RANDOM      = 400;
    localparam int NUM_DIRECTED    = 32;
    localparam int WATCHDOG_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 20;

    logic           i_clk;
    logic           i_arst_n;
    instr_in_t      i_instr;
    logic           o_instr_credit;
    retire_t        o_ret;
    logic           i_ret_credit;

    word_t          model_regs [32];
    instr_word_t    sent_q [$];
    int             cap_q [$];
    int             src_credits;
    int             owed;
    int             cycle;
    int             sent;
    int             retired;
    int             credit_pulses;
    int             errors;
    bit             lat_check;

    rv_core UUT
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr        (i_instr),
        .o_instr_credit (o_instr_credit),
        .o_ret          (o_ret),
        .i_ret_credit   (i_ret_credit)
    );

    bind rv_core rv_core_chk u_chk
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_ret_credits  (u_result.ret_credits),
        .i_buf_count    (u_buf.count),
        .i_ret_credit   (i_ret_credit),
        .i_ret_valid    (o_ret.valid)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic instr_word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3,
                                          input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // RV32I result of one instruction on the model register file.
    function automatic retire_t model_exec(input instr_word_t w);
        retire_t    r;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        logic       bad;
        opc = w[6:0];
        f7  = w[31:25];
        f3  = w[14:12];
        a   = model_regs[w[19:15]];
        bad = 1'b0;
        r   = '0;
        r.valid = 1'b1;
        r.rd    = w[11:7];
        if (opc == OPC_LUI)
            r.data = {w[31:12], 12'h000};
        else if (opc == OPC_OP_IMM)
        begin
            b = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1)
                bad = (f7 != 7'h00);
            else if (f3 == 3'd5)
                bad = (f7 != 7'h00) && (f7 != 7'h20);
            r.data = alu_model(f3, (f3 == 3'd5) && (f7 == 7'h20), a, b);
        end
        else if (opc == OPC_OP)
        begin
            b = model_regs[w[24:20]];
            if (f3 == 3'd0 || f3 == 3'd5)
                bad = (f7 != 7'h00) && (f7 != 7'h20);
            else
                bad = (f7 != 7'h00);
            r.data = alu_model(f3, f7 == 7'h20, a, b);
        end
        else
            bad = 1'b1;
        if (bad)
        begin
            r.illegal = 1'b1;
            r.data    = '0;
        end
        return r;
    endfunction

    function automatic instr_word_t random_instr();
        int unsigned kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        instr_word_t w;
        kind = $urandom_range(0, 99);
        rd   = reg_idx_t'($urandom_range(0, 7)); // Few registers, many hazards.
        rs1  = reg_idx_t'($urandom_range(0, 7));
        rs2  = reg_idx_t'($urandom_range(0, 7));
        f3   = 3'($urandom_range(0, 7));
        w    = $urandom();
        if (kind < 40)
        begin
            if (f3 == 3'd1)
                w[31:25] = 7'h00;
            else if (f3 == 3'd5)
                w[31:25] = ($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
            w = enc_i(w[31:20], rs1, f3, rd);
        end
        else if (kind < 75)
        begin
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) != 0) ? 7'h20 : 7'h00;
            w  = enc_r(f7, rs2, rs1, f3, rd);
        end
        else if (kind < 88)
            w = enc_u(w[31:12], rd);
        else if (kind < 95)
        begin
            opc = w[6:0];
            while (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI)
                opc = 7'($urandom());
            w[6:0] = opc;
        end
        else
            w = enc_r(7'h01, rs2, rs1, f3, rd); // M extension.
        return w;
    endfunction

    task automatic check_ret(input retire_t got, input retire_t exp, input instr_word_t w);
        if (got.illegal !== exp.illegal)
        begin
            errors++;
            $display("Fail o_ret.illegal: got 0x%0h expected 0x%0h (instr 0x%08h)",
                     got.illegal, exp.illegal, w);
        end
        if (got.rd !== exp.rd)
        begin
            errors++;
            $display("Fail o_ret.rd: got 0x%0h expected 0x%0h (instr 0x%08h)",
                     got.rd, exp.rd, w);
        end
        if (got.data !== exp.data)
        begin
            errors++;
            $display("Fail o_ret.data: got 0x%08h expected 0x%08h (instr 0x%08h)",
                     got.data, exp.data, w);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("Fail retire latency: got 0x%0h expected 0x%0h", got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic handle_retire();
        instr_word_t w;
        int          cap;
        retire_t     exp;
        owed++;
        retired++;
        if (owed > `RET_CREDITS)
        begin
            errors++;
            $display("Error: the core retired without a retire credit");
        end
        if (sent_q.size() == 0)
        begin
            errors++;
            $display("Error: a retire arrived with no instruction outstanding");
        end
        else
        begin
            w   = sent_q.pop_front();
            cap = cap_q.pop_front();
            exp = model_exec(w);
            check_ret(o_ret, exp, w);
            if (!exp.illegal && exp.rd != '0)
                model_regs[exp.rd] = exp.data;
            if (lat_check)
                check_latency(cycle - cap, 3);
        end
    endtask

    // One clock: sample outputs, then drive the next inputs.
    task automatic step(input bit eager);
        @(posedge i_clk);
        #1;
        cycle++;
        if (o_instr_credit)
        begin
            credit_pulses++;
            src_credits++;
            if (src_credits > `IBUF_DEPTH)
            begin
                errors++;
                $display("Error: more instruction credits came back than were used");
            end
        end
        if (o_ret.valid)
            handle_retire();
        i_instr = '0;
        if (owed > 0 && (eager || $urandom_range(0, 3) == 0))
        begin
            i_ret_credit = 1'b1;
            owed--;
        end
        else
            i_ret_credit = 1'b0;
    endtask

    task automatic send_instr(input instr_word_t w, input bit eager);
        while (src_credits == 0)
            step(eager);
        i_instr.valid = 1'b1;
        i_instr.instr = w;
        src_credits--;
        sent_q.push_back(w);
        cap_q.push_back(cycle + 1); // Captured at the next edge.
        sent++;
        step(eager);
    endtask

    task automatic drain();
        while (sent_q.size() != 0 || owed != 0)
            step(1'b1);
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout: no finish within %0d cycles, %0d of %0d retired",
                 WATCHDOG_CYCLES, retired, sent);
        $display("Errors: %0d", errors + 1);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int total;
        i_arst_n      = 1'b0;
        i_instr       = '0;
        i_ret_credit  = 1'b0;
        src_credits   = `IBUF_DEPTH;
        owed          = 0;
        cycle         = 0;
        sent          = 0;
        retired       = 0;
        credit_pulses = 0;
        errors        = 0;
        lat_check     = 1'b0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        void'($urandom(32'had42_5fc4));
        repeat (5) @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;

        // Random stream with gaps and a slow sink.
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            repeat ($urandom_range(0, 2)) step(1'b0);
            send_instr(random_instr(), 1'b0);
        end
        drain();

        // Back to back chain, each op reads the one before.
        send_instr(enc_i(12'h123, 5'd0, F3_ADD_SUB, 5'd1), 1'b1);
        send_instr(enc_i(12'hffb, 5'd1, F3_ADD_SUB, 5'd2), 1'b1);
        send_instr(enc_r(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 1'b1);
        send_instr(enc_r(7'h20, 5'd1, 5'd3, F3_ADD_SUB, 5'd4), 1'b1);
        send_instr(enc_r(7'h00, 5'd4, 5'd3, F3_XOR, 5'd5), 1'b1);
        send_instr(enc_r(7'h00, 5'd1, 5'd5, F3_SLL, 5'd6), 1'b1);
        send_instr(enc_r(7'h20, 5'd2, 5'd6, F3_SR, 5'd7), 1'b1);
        send_instr(enc_r(7'h00, 5'd7, 5'd6, F3_SLT, 5'd8), 1'b1);
        send_instr(enc_r(7'h00, 5'd8, 5'd7, F3_SLTU, 5'd9), 1'b1);
        send_instr(enc_r(7'h00, 5'd9, 5'd9, F3_OR, 5'd10), 1'b1);
        send_instr(enc_r(7'h00, 5'd10, 5'd7, F3_AND, 5'd11), 1'b1);
        send_instr(enc_r(7'h00, 5'd11, 5'd11, F3_SR, 5'd11), 1'b1);

        // LUI, then x0 written and read right after.
        send_instr(enc_u(20'habcde, 5'd12), 1'b1);
        send_instr(enc_i(12'h007, 5'd12, F3_ADD_SUB, 5'd0), 1'b1);
        send_instr(enc_u(20'h80001, 5'd0), 1'b1);
        send_instr(enc_r(7'h00, 5'd0, 5'd0, F3_ADD_SUB, 5'd13), 1'b1);
        send_instr(enc_i(12'h000, 5'd0, F3_OR, 5'd14), 1'b1);

        // Unsupported encodings aimed at x12.
        send_instr({12'h004, 5'd12, 3'b010, 5'd12, 7'b0000011}, 1'b1);
        send_instr({7'h00, 5'd1, 5'd12, 3'b000, 5'd8, 7'b1100011}, 1'b1);
        send_instr({20'h00010, 5'd12, 7'b1101111}, 1'b1);
        send_instr(enc_r(7'h01, 5'd2, 5'd12, F3_ADD_SUB, 5'd12), 1'b1);
        send_instr(enc_i(12'h405, 5'd12, F3_SLL, 5'd12), 1'b1);
        send_instr(enc_i(12'h000, 5'd12, F3_ADD_SUB, 5'd15), 1'b1);
        drain();

        // Single instructions into an idle pipeline.
        lat_check = 1'b1;
        send_instr(enc_i(12'h055, 5'd3, F3_XOR, 5'd16), 1'b1);
        drain();
        send_instr(enc_u(20'h12345, 5'd17), 1'b1);
        drain();
        lat_check = 1'b0;
        repeat (4) step(1'b1);

        check_count("o_instr_credit pulses", credit_pulses, sent);
        check_count("retire count", retired, sent);
        total = errors + UUT.u_chk.fail_count;
        $display("Errors: %0d, assertion failures: %0d", errors, UUT.u_chk.fail_count);
        if (total == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_instr_buf.sv
hdl/rv_decode.sv
hdl/rv_regs.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core.sv
testbench/rv_core_chk.sv
testbench/rv_core_tb.sv

// File: Makefile
# Verilator build and run for the rv_core testbench.

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
